// ==== filter_data_pkg.sv ====
/*
 * Packet data types for the graph engine filter stage.
 * Covers the width of one packet field, the width of the pass and drop
 * counters, and the default packet size used by the top level.
 */
package filter_data_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  // One packet field is a full data word
  localparam int FIELD_WIDTH = 32;

  // Pass and drop counters are half a word and wrap
  localparam int COUNT_WIDTH = 16;

  // --------------------------------------------------------------------------
  // Packet defaults
  // --------------------------------------------------------------------------

  // Fields per packet when the top level is not overridden
  localparam int DEFAULT_NUM_FIELDS = 4;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  // Unsigned field value
  typedef logic [FIELD_WIDTH-1:0] field_t;

  // Packet counter
  typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage : filter_data_pkg

// ==== filter_cfg_pkg.sv ====
/*
 * Filter configuration definitions.
 * Covers the operation codes the comparison kernel understands and the
 * word addresses of the configuration register bank.
 */
package filter_cfg_pkg;

  localparam int OP_WIDTH       = 4;
  localparam int CFG_ADDR_WIDTH = 4;

  typedef logic [OP_WIDTH-1:0]       filter_op_t;
  typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;

  // --------------------------------------------------------------------------
  // Filter operations
  // --------------------------------------------------------------------------

  // Pass-through of operand 0
  localparam filter_op_t FILTER_NOP         = 4'd0;
  // Compares, a verdict per masked pair
  localparam filter_op_t FILTER_GT          = 4'd1;
  localparam filter_op_t FILTER_LT          = 4'd2;
  localparam filter_op_t FILTER_EQ          = 4'd3;
  localparam filter_op_t FILTER_NOT_EQ      = 4'd4;
  // Ternary selects, always forward
  localparam filter_op_t FILTER_GT_TERN     = 4'd5;
  localparam filter_op_t FILTER_LT_TERN     = 4'd6;
  localparam filter_op_t FILTER_EQ_TERN     = 4'd7;
  localparam filter_op_t FILTER_NOT_EQ_TERN = 4'd8;
  // Codes 9 to 15 are undefined and raise no result

  // --------------------------------------------------------------------------
  // Configuration word map
  // --------------------------------------------------------------------------

  localparam cfg_addr_t CFG_ADDR_OP          = 4'd0;
  localparam cfg_addr_t CFG_ADDR_FILTER_MASK = 4'd1;
  localparam cfg_addr_t CFG_ADDR_CONST_MASK  = 4'd2;
  localparam cfg_addr_t CFG_ADDR_CONST_VALUE = 4'd3;
  // Row i of the operand routing matrix sits at this base plus i
  localparam cfg_addr_t CFG_ADDR_OPS_BASE    = 4'd4;

endpackage : filter_cfg_pkg

// ==== filter_config_regs.sv ====
/*
 * Filter configuration register bank.
 * Word writes update single configuration fields, and a commit strobe marks
 * the set as complete. Any write drops the valid flag until the next commit.
 */
`timescale 1ns/1ps

module filter_config_regs
  import filter_data_pkg::*;
  import filter_cfg_pkg::*;
#(
  parameter int NUM_FIELDS = DEFAULT_NUM_FIELDS
) (
  input  logic                             ap_clk,
  input  logic                             areset,
  input  logic                             cfg_write,
  input  cfg_addr_t                        cfg_addr,
  input  field_t                           cfg_wdata,
  input  logic                             cfg_commit,
  output logic                             config_valid,
  output filter_op_t                       filter_operation,
  output logic [NUM_FIELDS-1:0]            filter_mask,
  output logic [NUM_FIELDS-1:0]            const_mask,
  output field_t                           const_value,
  output logic [NUM_FIELDS*NUM_FIELDS-1:0] ops_mask
);

  // --------------------------------------------------------------------------
  // Word decode
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      filter_operation <= FILTER_NOP;
      filter_mask      <= '0;
      const_mask       <= '0;
      const_value      <= '0;
      ops_mask         <= '0;
    end else if (cfg_write) begin
      case (cfg_addr)
        CFG_ADDR_OP: begin
          filter_operation <= filter_op_t'(cfg_wdata[OP_WIDTH-1:0]);
        end
        CFG_ADDR_FILTER_MASK: begin
          filter_mask <= cfg_wdata[NUM_FIELDS-1:0];
        end
        CFG_ADDR_CONST_MASK: begin
          const_mask <= cfg_wdata[NUM_FIELDS-1:0];
        end
        CFG_ADDR_CONST_VALUE: begin
          const_value <= cfg_wdata;
        end
        default: begin
          // Routing rows, addresses past the last row fall through unused
          for (int i = 0; i < NUM_FIELDS; i++) begin
            if (cfg_addr == cfg_addr_t'(CFG_ADDR_OPS_BASE + i)) begin
              ops_mask[i*NUM_FIELDS +: NUM_FIELDS] <= cfg_wdata[NUM_FIELDS-1:0];
            end
          end
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Commit flag
  // --------------------------------------------------------------------------

  // A write wins over a commit in the same cycle
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      config_valid <= 1'b0;
    end else if (cfg_write) begin
      config_valid <= 1'b0;
    end else if (cfg_commit) begin
      config_valid <= 1'b1;
    end
  end

endmodule : filter_config_regs

// ==== filter_cond_kernel.sv ====
/*
 * Filter comparison kernel.
 * Stage 1 routes packet fields and constants into comparator operands,
 * stage 2 applies the configured compare or ternary select to neighbouring
 * operand pairs, and stage 3 registers the result packet and verdict.
 */
`timescale 1ns/1ps

module filter_cond_kernel
  import filter_data_pkg::*;
  import filter_cfg_pkg::*;
#(
  parameter int NUM_FIELDS = DEFAULT_NUM_FIELDS
) (
  input  logic                             ap_clk,
  input  logic                             areset,
  input  logic                             clear,
  input  logic                             config_valid,
  input  filter_op_t                       filter_operation,
  input  logic [NUM_FIELDS-1:0]            filter_mask,
  input  logic [NUM_FIELDS-1:0]            const_mask,
  input  field_t                           const_value,
  input  logic [NUM_FIELDS*NUM_FIELDS-1:0] ops_mask,
  input  logic                             data_valid,
  input  logic [NUM_FIELDS*FIELD_WIDTH-1:0] data,
  output logic                             result_flag,
  output logic [NUM_FIELDS*FIELD_WIDTH-1:0] result,
  output logic                             result_bool
);

  // Input fields and routing
  field_t                in_field  [NUM_FIELDS];
  field_t                row_pick  [NUM_FIELDS];
  field_t                route_ops [NUM_FIELDS];

  // Stage 1
  logic                  s1_valid;
  field_t                s1_ops [NUM_FIELDS];
  field_t                s1_org [1:NUM_FIELDS-1];

  // Stage 2
  field_t                sel_a;
  field_t                sel_b;
  logic                  eval_flag;
  field_t                eval_field0;
  logic [NUM_FIELDS-1:0] eval_pass;
  logic                  s2_flag;
  field_t                s2_field0;
  logic [NUM_FIELDS-1:0] s2_pass;
  field_t                s2_org [1:NUM_FIELDS-1];

  // Comparison shared by compare and ternary codes
  function automatic logic op_holds(filter_op_t op, field_t a, field_t b);
    case (op)
      FILTER_GT, FILTER_GT_TERN:         op_holds = a > b;
      FILTER_LT, FILTER_LT_TERN:         op_holds = a < b;
      FILTER_EQ, FILTER_EQ_TERN:         op_holds = a == b;
      FILTER_NOT_EQ, FILTER_NOT_EQ_TERN: op_holds = a != b;
      default:                           op_holds = 1'b0;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Stage 1, operand routing
  // --------------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      in_field[i] = data[i*FIELD_WIDTH +: FIELD_WIDTH];
    end
    for (int i = 0; i < NUM_FIELDS; i++) begin
      // Empty row keeps the field in place, else the highest set bit wins
      row_pick[i] = in_field[i];
      for (int j = 0; j < NUM_FIELDS; j++) begin
        if (ops_mask[i*NUM_FIELDS + j]) begin
          row_pick[i] = in_field[j];
        end
      end
      route_ops[i] = const_mask[i] ? const_value : row_pick[i];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= data_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (data_valid) begin
      for (int i = 0; i < NUM_FIELDS; i++) begin
        s1_ops[i] <= route_ops[i];
      end
      for (int i = 1; i < NUM_FIELDS; i++) begin
        s1_org[i] <= row_pick[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stage 2, evaluation
  // --------------------------------------------------------------------------

  always_comb begin
    // Selected pair is the highest masked one
    sel_a = s1_ops[0];
    sel_b = s1_ops[0];
    for (int i = 0; i < NUM_FIELDS-1; i++) begin
      if (filter_mask[i]) begin
        sel_a = s1_ops[i];
        sel_b = s1_ops[i+1];
      end
    end

    eval_flag   = config_valid & s1_valid;
    eval_field0 = s1_ops[0];
    eval_pass   = '1;
    case (filter_operation)
      FILTER_NOP: begin
        eval_field0 = s1_ops[0];
      end
      FILTER_GT, FILTER_LT, FILTER_EQ, FILTER_NOT_EQ: begin
        eval_field0 = sel_a;
        for (int i = 0; i < NUM_FIELDS-1; i++) begin
          if (filter_mask[i]) begin
            eval_pass[i] = op_holds(filter_operation, s1_ops[i], s1_ops[i+1]);
          end
        end
      end
      FILTER_GT_TERN, FILTER_LT_TERN, FILTER_EQ_TERN, FILTER_NOT_EQ_TERN: begin
        eval_field0 = op_holds(filter_operation, sel_a, sel_b) ? sel_a : sel_b;
      end
      default: begin
        eval_flag = 1'b0;
      end
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset | clear) begin
      s2_flag <= 1'b0;
      s2_pass <= '1;
    end else begin
      s2_flag <= eval_flag;
      s2_pass <= eval_pass;
    end
  end

  // Originals ride along so back-to-back packets stay aligned
  always_ff @(posedge ap_clk) begin
    s2_field0 <= eval_field0;
    s2_org    <= s1_org;
  end

  // --------------------------------------------------------------------------
  // Stage 3, output registers
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      result_flag <= 1'b0;
      result_bool <= 1'b1;
    end else begin
      result_flag <= s2_flag;
      // Unmasked positions never veto
      result_bool <= &(s2_pass | ~filter_mask);
    end
  end

  always_ff @(posedge ap_clk) begin
    result[FIELD_WIDTH-1:0] <= s2_field0;
    for (int i = 1; i < NUM_FIELDS; i++) begin
      result[i*FIELD_WIDTH +: FIELD_WIDTH] <= s2_org[i];
    end
  end

endmodule : filter_cond_kernel

// ==== filter_packet_gate.sv ====
/*
 * Filter output gate.
 * Forwards packets whose verdict is true and counts passed and dropped
 * packets. Both counters wrap and return to zero on clear.
 */
`timescale 1ns/1ps

module filter_packet_gate
  import filter_data_pkg::*;
#(
  parameter int NUM_FIELDS = DEFAULT_NUM_FIELDS
) (
  input  logic                              ap_clk,
  input  logic                              areset,
  input  logic                              clear,
  input  logic                              result_flag,
  input  logic [NUM_FIELDS*FIELD_WIDTH-1:0] result,
  input  logic                              result_bool,
  output logic                              out_valid,
  output logic [NUM_FIELDS*FIELD_WIDTH-1:0] out_data,
  output count_t                            pass_count,
  output count_t                            drop_count
);

  logic forward;
  logic drop;

  assign forward = result_flag & result_bool;
  assign drop    = result_flag & ~result_bool;

  // --------------------------------------------------------------------------
  // Forwarding
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= forward;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (forward) begin
      out_data <= result;
    end
  end

  // --------------------------------------------------------------------------
  // Counters
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset | clear) begin
      pass_count <= '0;
      drop_count <= '0;
    end else begin
      if (forward) begin
        pass_count <= pass_count + count_t'(1);
      end
      if (drop) begin
        drop_count <= drop_count + count_t'(1);
      end
    end
  end

endmodule : filter_packet_gate

// ==== filter_engine_top.sv ====
/*
 * Filter engine top level.
 * Joins the configuration register bank, the comparison kernel and the
 * output gate. A packet takes four cycles from input to verdict.
 */
`timescale 1ns/1ps

module filter_engine_top
  import filter_data_pkg::*;
  import filter_cfg_pkg::*;
#(
  parameter int NUM_FIELDS = DEFAULT_NUM_FIELDS
) (
  input  logic                              ap_clk,
  input  logic                              areset,
  input  logic                              clear,
  input  logic                              cfg_write,
  input  cfg_addr_t                         cfg_addr,
  input  field_t                            cfg_wdata,
  input  logic                              cfg_commit,
  input  logic                              in_valid,
  input  logic [NUM_FIELDS*FIELD_WIDTH-1:0] in_data,
  output logic                              out_valid,
  output logic [NUM_FIELDS*FIELD_WIDTH-1:0] out_data,
  output count_t                            pass_count,
  output count_t                            drop_count
);

  // Configuration fan-out
  logic                             config_valid;
  filter_op_t                       filter_operation;
  logic [NUM_FIELDS-1:0]            filter_mask;
  logic [NUM_FIELDS-1:0]            const_mask;
  field_t                           const_value;
  logic [NUM_FIELDS*NUM_FIELDS-1:0] ops_mask;

  // Kernel to gate
  logic                              result_flag;
  logic [NUM_FIELDS*FIELD_WIDTH-1:0] result;
  logic                              result_bool;

  filter_config_regs #(
    .NUM_FIELDS(NUM_FIELDS)
  ) u_filter_config_regs (
    .ap_clk          (ap_clk),
    .areset          (areset),
    .cfg_write       (cfg_write),
    .cfg_addr        (cfg_addr),
    .cfg_wdata       (cfg_wdata),
    .cfg_commit      (cfg_commit),
    .config_valid    (config_valid),
    .filter_operation(filter_operation),
    .filter_mask     (filter_mask),
    .const_mask      (const_mask),
    .const_value     (const_value),
    .ops_mask        (ops_mask)
  );

  filter_cond_kernel #(
    .NUM_FIELDS(NUM_FIELDS)
  ) u_filter_cond_kernel (
    .ap_clk          (ap_clk),
    .areset          (areset),
    .clear           (clear),
    .config_valid    (config_valid),
    .filter_operation(filter_operation),
    .filter_mask     (filter_mask),
    .const_mask      (const_mask),
    .const_value     (const_value),
    .ops_mask        (ops_mask),
    .data_valid      (in_valid),
    .data            (in_data),
    .result_flag     (result_flag),
    .result          (result),
    .result_bool     (result_bool)
  );

  filter_packet_gate #(
    .NUM_FIELDS(NUM_FIELDS)
  ) u_filter_packet_gate (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .clear      (clear),
    .result_flag(result_flag),
    .result     (result),
    .result_bool(result_bool),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .pass_count (pass_count),
    .drop_count (drop_count)
  );

endmodule : filter_engine_top

// ==== filter_engine_chk.sv ====
/*
 * Protocol checks for the filter engine top level.
 * Bound to every filter_engine_top instance, watches the output strobe
 * and the pass and drop counters.
 */
`timescale 1ns/1ps

module filter_engine_chk
  import filter_data_pkg::*;
(
  input logic   ap_clk,
  input logic   areset,
  input logic   clear,
  input logic   in_valid,
  input logic   out_valid,
  input count_t pass_count,
  input count_t drop_count
);

  // No output while in reset and on the first cycle out of it
  out_low_in_reset: assert property (@(posedge ap_clk)
    areset |=> !out_valid [*2])
    else $error("out_valid high during or right after reset");

  // A drop and a forward never share a cycle
  no_drop_with_out: assert property (@(posedge ap_clk) disable iff (areset)
    (!$past(clear) && drop_count != $past(drop_count)) |-> !out_valid)
    else $error("out_valid high while drop_count changed");

  pass_step_one: assert property (@(posedge ap_clk) disable iff (areset)
    (!$past(clear) && !$past(areset)) |->
      (pass_count == $past(pass_count) ||
       pass_count == count_t'($past(pass_count) + count_t'(1))))
    else $error("pass_count rose by more than one");

  // Four cycles from accepted packet to forwarded packet
  out_after_in: assert property (@(posedge ap_clk) disable iff (areset)
    out_valid |-> $past(in_valid, 4))
    else $error("out_valid without in_valid four cycles earlier");

endmodule : filter_engine_chk

bind filter_engine_top filter_engine_chk u_filter_engine_chk (
  .ap_clk    (ap_clk),
  .areset    (areset),
  .clear     (clear),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .pass_count(pass_count),
  .drop_count(drop_count)
);

// ==== filter_engine_tb.sv ====
/*
 * Table-driven testbench for the filter engine.
 * Each table row loads a configuration, sends one packet and checks the
 * verdict four cycles later. A burst phase and a counter clear follow.
 */
`timescale 1ns/1ps

module filter_engine_tb;
  import filter_data_pkg::*;
  import filter_cfg_pkg::*;

  localparam int NF     = 4;
  localparam int PW     = NF * FIELD_WIDTH;
  localparam int MAX    = 40;
  localparam int K_DROP = 0;
  localparam int K_PASS = 1;
  localparam int K_NONE = 2;

  logic ap_clk = 1'b0;
  logic areset;
  logic clear;
  logic cfg_write;
  logic cfg_commit;
  logic in_valid;
  logic out_valid;
  cfg_addr_t cfg_addr;
  field_t cfg_wdata;
  logic [PW-1:0] in_data;
  logic [PW-1:0] out_data;
  count_t pass_count;
  count_t drop_count;

  // Stimulus table
  string      t_name [MAX];
  filter_op_t t_op [MAX];
  logic [3:0] t_fmask [MAX];
  logic [3:0] t_cmask [MAX];
  field_t     t_cval [MAX];
  logic [15:0] t_rows [MAX];
  logic [PW-1:0] t_pkt [MAX];
  logic       t_commit [MAX];
  int         t_kind [MAX];
  logic [PW-1:0] t_exp [MAX];
  int num_entries = 0;
  int exp_pass = 0;
  int exp_drop = 0;

  filter_engine_top #(.NUM_FIELDS(NF)) u_filter_engine_top (
    .ap_clk(ap_clk), .areset(areset), .clear(clear), .cfg_write(cfg_write),
    .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_commit(cfg_commit),
    .in_valid(in_valid), .in_data(in_data), .out_valid(out_valid),
    .out_data(out_data), .pass_count(pass_count), .drop_count(drop_count)
  );

  always #4 ap_clk = ~ap_clk;

  function automatic logic [PW-1:0] pk(field_t a, field_t b, field_t c, field_t d);
    pk = {d, c, b, a};
  endfunction

  // Codes 1..8 fold onto GT, LT, EQ, NOT_EQ
  function automatic logic holds(filter_op_t op, field_t a, field_t b);
    int kind;
    kind = (int'(op) - 1) % 4;
    holds = (kind == 0) ? (a > b) : (kind == 1) ? (a < b) :
            (kind == 2) ? (a == b) : (a != b);
  endfunction

  // Reference model of routing, evaluation and verdict
  task automatic model_filter(input filter_op_t op, input logic [3:0] fmask, cmask,
                              input field_t cval, input logic [15:0] rows,
                              input logic [PW-1:0] pkt, output int kind,
                              output logic [PW-1:0] exp_out);
    field_t f [NF];
    field_t org [NF];
    field_t opnd [NF];
    field_t field0;
    logic verdict;
    logic found;
    int sel;
    for (int i = 0; i < NF; i++) f[i] = pkt[i*FIELD_WIDTH +: FIELD_WIDTH];
    for (int i = 0; i < NF; i++) begin
      org[i] = f[i];
      found = 1'b0;
      for (int j = NF-1; j >= 0; j--) begin
        if (!found && rows[i*NF + j]) begin
          org[i] = f[j];
          found = 1'b1;
        end
      end
      opnd[i] = cmask[i] ? cval : org[i];
    end
    sel = -1;
    for (int i = 0; i < NF-1; i++) if (fmask[i]) sel = i;
    verdict = 1'b1;
    field0 = opnd[0];
    if (op >= 1 && op <= 4) begin
      for (int i = 0; i < NF-1; i++) begin
        if (fmask[i] && !holds(op, opnd[i], opnd[i+1])) verdict = 1'b0;
      end
      if (sel >= 0) field0 = opnd[sel];
    end else if (op >= 5 && op <= 8 && sel >= 0) begin
      field0 = holds(op, opnd[sel], opnd[sel+1]) ? opnd[sel] : opnd[sel+1];
    end
    kind = (op > 8) ? K_NONE : (verdict ? K_PASS : K_DROP);
    exp_out = {org[3], org[2], org[1], field0};
  endtask

  task automatic add_row(string name, filter_op_t op, logic [3:0] fmask, cmask,
                         field_t cval, logic [15:0] rows, logic [PW-1:0] pkt,
                         logic commit, int kind, logic [PW-1:0] exp);
    t_name[num_entries] = name;
    t_op[num_entries] = op;
    t_fmask[num_entries] = fmask;
    t_cmask[num_entries] = cmask;
    t_cval[num_entries] = cval;
    t_rows[num_entries] = rows;
    t_pkt[num_entries] = pkt;
    t_commit[num_entries] = commit;
    t_kind[num_entries] = kind;
    t_exp[num_entries] = exp;
    num_entries++;
  endtask

  task automatic check_equal(string name, string what, logic [PW-1:0] exp, act);
    assert (exp === act) else begin
      $display("** Error %s: %s expected %0h, actual %0h", name, what, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic write_cfg(cfg_addr_t addr, field_t value);
    cfg_write = 1'b1;
    cfg_addr = addr;
    cfg_wdata = value;
    @(posedge ap_clk);
    #1 cfg_write = 1'b0;
  endtask

  task automatic load_config(int k);
    write_cfg(CFG_ADDR_OP, field_t'(t_op[k]));
    write_cfg(CFG_ADDR_FILTER_MASK, field_t'(t_fmask[k]));
    write_cfg(CFG_ADDR_CONST_MASK, field_t'(t_cmask[k]));
    write_cfg(CFG_ADDR_CONST_VALUE, t_cval[k]);
    for (int r = 0; r < NF; r++) begin
      write_cfg(cfg_addr_t'(CFG_ADDR_OPS_BASE + r), field_t'(t_rows[k][r*NF +: NF]));
    end
    if (t_commit[k]) begin
      cfg_commit = 1'b1;
      @(posedge ap_clk);
      #1 cfg_commit = 1'b0;
    end
  endtask

  task automatic check_verdict(int k);
    check_equal(t_name[k], "out_valid", PW'(t_kind[k] == K_PASS), PW'(out_valid));
    if (t_kind[k] == K_PASS) check_equal(t_name[k], "out_data", t_exp[k], out_data);
    if (t_kind[k] == K_PASS) exp_pass++;
    if (t_kind[k] == K_DROP) exp_drop++;
    check_equal(t_name[k], "pass_count", PW'(exp_pass), PW'(pass_count));
    check_equal(t_name[k], "drop_count", PW'(exp_drop), PW'(drop_count));
  endtask

  task automatic build_table();
    int kind;
    logic [PW-1:0] exp;
    add_row("gt_larger", FILTER_GT, 4'b0001, 0, 0, 0, pk(5,3,7,9), 1, K_PASS, pk(5,3,7,9));
    add_row("gt_equal", FILTER_GT, 4'b0001, 0, 0, 0, pk(4,4,1,1), 1, K_DROP, 0);
    add_row("gt_smaller", FILTER_GT, 4'b0001, 0, 0, 0, pk(2,3,0,0), 1, K_DROP, 0);
    add_row("gt_pair1", FILTER_GT, 4'b0010, 0, 0, 0, pk(0,9,4,0), 1, K_PASS, pk(9,9,4,0));
    add_row("lt_smaller", FILTER_LT, 4'b0001, 0, 0, 0, pk(2,3,0,0), 1, K_PASS, pk(2,3,0,0));
    add_row("lt_equal", FILTER_LT, 4'b0001, 0, 0, 0, pk(3,3,0,0), 1, K_DROP, 0);
    add_row("lt_larger", FILTER_LT, 4'b0001, 0, 0, 0, pk(5,3,0,0), 1, K_DROP, 0);
    add_row("eq_equal", FILTER_EQ, 4'b0001, 0, 0, 0, pk(6,6,1,2), 1, K_PASS, pk(6,6,1,2));
    add_row("eq_diff", FILTER_EQ, 4'b0001, 0, 0, 0, pk(6,7,1,2), 1, K_DROP, 0);
    add_row("eq_larger", FILTER_EQ, 4'b0001, 0, 0, 0, pk(7,6,1,2), 1, K_DROP, 0);
    add_row("neq_diff", FILTER_NOT_EQ, 4'b0001, 0, 0, 0, pk(6,7,1,2), 1, K_PASS,
            pk(6,7,1,2));
    add_row("neq_larger", FILTER_NOT_EQ, 4'b0001, 0, 0, 0, pk(7,6,1,2), 1, K_PASS,
            pk(7,6,1,2));
    add_row("neq_equal", FILTER_NOT_EQ, 4'b0001, 0, 0, 0, pk(6,6,1,2), 1, K_DROP, 0);
    add_row("gt_tern", FILTER_GT_TERN, 4'b0001, 0, 0, 0, pk(3,8,1,1), 1, K_PASS,
            pk(8,8,1,1));
    add_row("lt_tern", FILTER_LT_TERN, 4'b0001, 0, 0, 0, pk(3,8,1,1), 1, K_PASS,
            pk(3,8,1,1));
    add_row("eq_tern", FILTER_EQ_TERN, 4'b0100, 0, 0, 0, pk(1,2,5,5), 1, K_PASS,
            pk(5,2,5,5));
    add_row("eq_tern_miss", FILTER_EQ_TERN, 4'b0100, 0, 0, 0, pk(1,2,5,6), 1, K_PASS,
            pk(6,2,5,6));
    add_row("neq_tern", FILTER_NOT_EQ_TERN, 4'b0100, 0, 0, 0, pk(1,2,7,4), 1, K_PASS,
            pk(7,2,7,4));
    add_row("nop", FILTER_NOP, 4'b0000, 0, 0, 0, pk(7,1,2,3), 1, K_PASS, pk(7,1,2,3));
    add_row("const_op0", FILTER_GT, 4'b0001, 4'b0001, 10, 0, pk(1,5,2,3), 1, K_PASS,
            pk(10,5,2,3));
    add_row("permute", FILTER_EQ, 4'b0001, 0, 0, 16'h2184, pk(1,2,9,9), 1, K_PASS,
            pk(9,9,1,2));
    add_row("multi_pass", FILTER_LT, 4'b0011, 0, 0, 0, pk(1,2,3,0), 1, K_PASS,
            pk(2,2,3,0));
    add_row("multi_drop", FILTER_LT, 4'b0111, 0, 0, 0, pk(1,2,3,0), 1, K_DROP, 0);
    add_row("undefined_op", filter_op_t'(9), 4'b0001, 0, 0, 0, pk(5,3,0,0), 1, K_NONE, 0);
    add_row("uncommitted", FILTER_GT, 4'b0001, 0, 0, 0, pk(5,3,0,0), 0, K_NONE, 0);
    for (int r = 0; r < 8; r++) begin
      t_op[num_entries] = filter_op_t'($urandom % 9);
      t_fmask[num_entries] = 4'($urandom);
      t_cmask[num_entries] = 4'($urandom % 3);
      t_cval[num_entries] = $urandom % 4;
      t_rows[num_entries] = 16'($urandom);
      t_pkt[num_entries] = pk($urandom % 4, $urandom % 4, $urandom % 4, $urandom % 4);
      model_filter(t_op[num_entries], t_fmask[num_entries], t_cmask[num_entries],
                   t_cval[num_entries], t_rows[num_entries], t_pkt[num_entries],
                   kind, exp);
      add_row($sformatf("random_%0d", r), t_op[num_entries], t_fmask[num_entries],
              t_cmask[num_entries], t_cval[num_entries], t_rows[num_entries],
              t_pkt[num_entries], 1, kind, exp);
    end
  endtask

  // Watchdog sized from the table length
  initial begin
    #1;
    repeat (num_entries * 40 + 100) @(posedge ap_clk);
    $display("Timeout: simulation did not finish in time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int first;
    areset = 1'b1;
    clear = 1'b0;
    cfg_write = 1'b0;
    cfg_commit = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    in_valid = 1'b0;
    in_data = '0;
    void'($urandom(32'ha6cb));
    build_table();
    repeat (3) @(posedge ap_clk);
    #1 areset = 1'b0;

    // ------------------------------------------------------------------------
    // Table, one packet per row
    // ------------------------------------------------------------------------
    for (int k = 0; k < num_entries; k++) begin
      load_config(k);
      in_valid = 1'b1;
      in_data = t_pkt[k];
      @(posedge ap_clk);
      #1 in_valid = 1'b0;
      repeat (3) @(posedge ap_clk);
      #1;
      check_verdict(k);
    end

    // ------------------------------------------------------------------------
    // Burst of back-to-back packets under one configuration
    // ------------------------------------------------------------------------
    first = num_entries;
    for (int b = 0; b < 6; b++) begin
      logic [PW-1:0] p;
      int kind;
      logic [PW-1:0] exp;
      p = pk($urandom % 4, $urandom % 4, $urandom % 4, $urandom % 4);
      model_filter(FILTER_LT, 4'b0001, 0, 0, 0, p, kind, exp);
      add_row($sformatf("burst_%0d", b), FILTER_LT, 4'b0001, 0, 0, 0, p, 1, kind, exp);
    end
    load_config(first);
    for (int s = 0; s < num_entries - first + 4; s++) begin
      if (s >= 4) check_verdict(first + s - 4);
      in_valid = (first + s < num_entries);
      if (first + s < num_entries) in_data = t_pkt[first + s];
      @(posedge ap_clk);
      #1;
    end

    // Clear returns both counters to zero
    clear = 1'b1;
    @(posedge ap_clk);
    #1 clear = 1'b0;
    check_equal("clear", "pass_count", 0, PW'(pass_count));
    check_equal("clear", "drop_count", 0, PW'(drop_count));

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : filter_engine_tb

// ==== verilog.f ====
filter_data_pkg.sv
filter_cfg_pkg.sv
filter_config_regs.sv
filter_cond_kernel.sv
filter_packet_gate.sv
filter_engine_top.sv
filter_engine_chk.sv
filter_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the filter engine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing -Wno-fatal \
  --top-module filter_engine_tb \
  -f verilog.f \
  -o sim_filter_engine

# The simulator exits non-zero on failure; the log decides the verdict
./obj_dir/sim_filter_engine > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "No pass line found in sim.log"
  exit 1
fi
exit 0
